// ==== Makefile ====
# Verilator build and run for the MIPS core testbench

VERILATOR ?= verilator
TOP       ?= tb_mips_core
FILELIST  ?= build.f
BUILD_DIR ?= obj_dir
LOG       ?= sim.log
PASS_MSG  ?= PASS: all tests
VFLAGS    ?= --binary --timing --assert -Wno-fatal

SOURCES := $(wildcard source/*.sv) $(wildcard bench/*.sv)
SIM_BIN := $(BUILD_DIR)/V$(TOP)

.PHONY: all compile run clean

all: run

compile: $(SIM_BIN)

$(SIM_BIN): $(FILELIST) $(SOURCES)
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) --Mdir $(BUILD_DIR) -f $(FILELIST)

run: compile
	-./$(SIM_BIN) > $(LOG) 2>&1
	@cat $(LOG)
	@grep -q "$(PASS_MSG)" $(LOG)

clean:
	rm -rf $(BUILD_DIR) $(LOG)

// ==== bench/tb_mips_core.sv ====
// Testbench for the MIPS core
// Loads a hand-assembled program while halted, runs it, then reads the
// register file back through the debug port and checks the PC on the way
`timescale 1ns/1ps
`default_nettype none

module tb_mips_core;

    // MIPS primary opcodes and R-type function codes
    localparam logic [5:0] OPC_J     = 6'h02;
    localparam logic [5:0] OPC_JAL   = 6'h03;
    localparam logic [5:0] OPC_BEQ   = 6'h04;
    localparam logic [5:0] OPC_BNE   = 6'h05;
    localparam logic [5:0] OPC_ADDIU = 6'h09;
    localparam logic [5:0] OPC_ORI   = 6'h0D;
    localparam logic [5:0] OPC_LUI   = 6'h0F;
    localparam logic [5:0] OPC_LW    = 6'h23;
    localparam logic [5:0] OPC_SW    = 6'h2B;
    localparam logic [5:0] FN_JR     = 6'h08;
    localparam logic [5:0] FN_ADDU   = 6'h21;
    localparam logic [5:0] FN_SUBU   = 6'h23;
    localparam logic [5:0] FN_AND    = 6'h24;
    localparam logic [5:0] FN_OR     = 6'h25;
    localparam logic [5:0] FN_XOR    = 6'h26;
    localparam logic [5:0] FN_SLT    = 6'h2A;
    localparam int         STRAIGHT_LEN = 15;    // Enabled cycles before the BEQ redirects

    logic        i_clk;
    logic        i_reset;
    logic        i_enable;
    logic        i_write;
    logic [31:0] i_instruction;
    logic [4:0]  i_dbg_reg_addr;
    logic [31:0] o_dbg_reg_data;
    logic [31:0] o_pc;

    logic [31:0] program_words [$];
    logic [4:0]  expect_regs [$];
    logic [31:0] expect_vals [$];
    int          error_count;
    int          cycle_count;
    int          timeout_limit;

    mips_core i_mips_core (
        .i_clk, .i_reset, .i_enable, .i_write, .i_instruction,
        .i_dbg_reg_addr, .o_dbg_reg_data, .o_pc
    );

    always #10 i_clk = ~i_clk;

    function automatic logic [31:0] encode_r(input logic [5:0] funct, input logic [4:0] rs,
                                             input logic [4:0] rt, input logic [4:0] rd);
        return {6'h00, rs, rt, rd, 5'd0, funct};
    endfunction

    function automatic logic [31:0] encode_i(input logic [5:0] op, input logic [4:0] rs,
                                             input logic [4:0] rt, input logic [15:0] imm);
        return {op, rs, rt, imm};
    endfunction

    function automatic logic [31:0] encode_j(input logic [5:0] op, input logic [25:0] index);
        return {op, index};
    endfunction

    task automatic fail_run();
        $display("FAIL: see errors above");
        $fatal(1);
    endtask

    task automatic check_word(input string what, input logic [31:0] actual,
                              input logic [31:0] expected);
        assert (actual === expected) else begin
            error_count++;
            $display("ERROR: time %0t: %s is %08h, expected %08h",
                     $time, what, actual, expected);
            fail_run();
        end
    endtask

    // Program table with the word index on the left
    task automatic assemble_program();
        program_words.push_back(encode_i(OPC_ADDIU, 5'd0, 5'd1, 16'd5));        // 0  r1 = 5
        program_words.push_back(encode_i(OPC_ADDIU, 5'd0, 5'd2, 16'hFF00));     // 1  r2 = -256
        program_words.push_back(encode_i(OPC_LUI, 5'd0, 5'd3, 16'h1234));       // 2
        program_words.push_back(encode_r(FN_ADDU, 5'd1, 5'd2, 5'd4));            // 3
        program_words.push_back(encode_r(FN_SUBU, 5'd1, 5'd2, 5'd5));            // 4
        program_words.push_back(encode_i(OPC_ORI, 5'd3, 5'd6, 16'h5678));        // 5
        program_words.push_back(encode_r(FN_SLT, 5'd2, 5'd1, 5'd8));             // 6
        program_words.push_back(encode_r(FN_OR, 5'd6, 5'd2, 5'd7));              // 7
        program_words.push_back(encode_r(FN_AND, 5'd6, 5'd2, 5'd9));             // 8
        program_words.push_back(encode_r(FN_XOR, 5'd6, 5'd2, 5'd10));            // 9
        program_words.push_back(encode_i(OPC_ADDIU, 5'd0, 5'd0, 16'd77));       // 10 r0 write
        program_words.push_back(encode_i(OPC_SW, 5'd0, 5'd6, 16'd16));          // 11
        program_words.push_back(encode_i(OPC_ADDIU, 5'd1, 5'd11, 16'd1));       // 12 spacer
        program_words.push_back(encode_i(OPC_LW, 5'd0, 5'd12, 16'd16));         // 13
        program_words.push_back(encode_i(OPC_BEQ, 5'd1, 5'd1, 16'd3));          // 14 to 18
        program_words.push_back(encode_i(OPC_ADDIU, 5'd0, 5'd13, 16'h0011));    // 15 slot
        program_words.push_back(encode_i(OPC_ADDIU, 5'd0, 5'd7, 16'h0BAD));     // 16 skipped
        program_words.push_back(encode_i(OPC_ADDIU, 5'd0, 5'd9, 16'h0BAD));     // 17 skipped
        program_words.push_back(encode_i(OPC_BNE, 5'd1, 5'd1, 16'd3));          // 18 falls through
        program_words.push_back(encode_i(OPC_ADDIU, 5'd0, 5'd16, 16'h0022));    // 19 slot
        program_words.push_back(encode_i(OPC_ADDIU, 5'd0, 5'd17, 16'h0033));    // 20
        program_words.push_back(encode_i(OPC_ADDIU, 5'd0, 5'd18, 16'h0044));    // 21
        program_words.push_back(encode_i(OPC_ADDIU, 5'd0, 5'd19, 16'd0));       // 22 counter
        program_words.push_back(encode_j(OPC_JAL, 26'd28));                     // 23 call
        program_words.push_back(encode_i(OPC_ADDIU, 5'd0, 5'd20, 16'h0055));    // 24 slot
        program_words.push_back(encode_i(OPC_ADDIU, 5'd19, 5'd19, 16'd1));     // 25 return
        program_words.push_back(encode_j(OPC_J, 26'd31));                       // 26 to halt
        program_words.push_back(32'h0000_0000);                                 // 27 slot
        program_words.push_back(encode_i(OPC_ADDIU, 5'd0, 5'd21, 16'h0066));    // 28 callee
        program_words.push_back(encode_r(FN_JR, 5'd31, 5'd0, 5'd0));            // 29
        program_words.push_back(32'h0000_0000);                                 // 30 slot
        program_words.push_back(encode_i(OPC_BEQ, 5'd0, 5'd0, 16'hFFFF));       // 31 halt loop
        program_words.push_back(32'h0000_0000);                                 // 32 slot
    endtask

    task automatic add_expect(input logic [4:0] reg_addr, input logic [31:0] value);
        expect_regs.push_back(reg_addr);
        expect_vals.push_back(value);
    endtask

    task automatic build_expectations();
        add_expect(5'd0, 32'h0000_0000);      // Write to r0 dropped
        add_expect(5'd1, 32'h0000_0005);
        add_expect(5'd2, 32'hFFFF_FF00);
        add_expect(5'd3, 32'h1234_0000);
        add_expect(5'd4, 32'hFFFF_FF05);      // 5 + -256
        add_expect(5'd5, 32'h0000_0105);      // 5 - -256
        add_expect(5'd6, 32'h1234_5678);
        add_expect(5'd7, 32'hFFFF_FF78);      // Marker skipped by BEQ
        add_expect(5'd8, 32'h0000_0001);      // -256 < 5 signed
        add_expect(5'd9, 32'h1234_5600);      // Marker skipped by BEQ
        add_expect(5'd10, 32'hEDCB_A978);
        add_expect(5'd11, 32'h0000_0006);
        add_expect(5'd12, 32'h1234_5678);     // Loaded back from word 4
        add_expect(5'd13, 32'h0000_0011);
        add_expect(5'd16, 32'h0000_0022);
        add_expect(5'd17, 32'h0000_0033);
        add_expect(5'd18, 32'h0000_0044);
        add_expect(5'd19, 32'h0000_0001);     // Only bumped after JR
        add_expect(5'd20, 32'h0000_0055);
        add_expect(5'd21, 32'h0000_0066);
        add_expect(5'd31, 32'd100);           // JAL at 92 plus 8
    endtask

    task automatic load_program();
        for (int i = 0; i < program_words.size(); i++) begin
            @(posedge i_clk);
            i_write       <= 1'b1;
            i_instruction <= program_words[i];
            @(negedge i_clk);
            check_word("PC while loading", o_pc, 32'd0);
        end
    endtask

    task automatic run_program(input int run_len);
        @(posedge i_clk);
        i_write  <= 1'b0;                    // Last word is stored at this edge
        i_enable <= 1'b1;
        for (int k = 1; k <= run_len; k++) begin
            @(posedge i_clk);
            if (k == run_len) begin
                i_enable <= 1'b0;
            end
            @(negedge i_clk);
            if (k <= STRAIGHT_LEN) begin
                check_word($sformatf("PC at run cycle %0d", k), o_pc, 32'(4 * k));
            end
        end
    endtask

    task automatic check_registers();
        logic [31:0] held_pc;
        held_pc = o_pc;
        for (int i = 0; i < expect_regs.size(); i++) begin
            @(posedge i_clk);
            i_dbg_reg_addr <= expect_regs[i];
            @(negedge i_clk);
            check_word($sformatf("r%0d", expect_regs[i]), o_dbg_reg_data, expect_vals[i]);
            check_word("PC while halted", o_pc, held_pc);
        end
    endtask

    initial begin : watchdog
        cycle_count = 0;
        @(posedge i_clk);
        while (cycle_count < timeout_limit) begin
            @(posedge i_clk);
            cycle_count++;
        end
        $display("Timeout: the run did not end within %0d cycles", timeout_limit);
        fail_run();
    end

    initial begin
        i_clk          = 1'b0;
        i_reset        = 1'b1;
        i_enable       = 1'b0;
        i_write        = 1'b0;
        i_instruction  = '0;
        i_dbg_reg_addr = '0;
        error_count    = 0;
        assemble_program();
        build_expectations();
        timeout_limit = program_words.size() + (program_words.size() + 4)
                      + expect_regs.size() + 50;

        repeat (2) @(posedge i_clk);
        i_reset <= 1'b0;
        @(negedge i_clk);
        check_word("PC after reset", o_pc, 32'd0);

        load_program();
        run_program(program_words.size() + 4);
        check_registers();

        if (error_count == 0) begin
            $display("PASS: all tests");
            $finish;
        end else begin
            fail_run();
        end
    end

endmodule

`default_nettype wire

// ==== build.f ====
source/mips_pkg.sv
source/instr_fetch.sv
source/instr_decode.sv
source/instr_execute.sv
source/result_stage.sv
source/mips_core.sv
bench/tb_mips_core.sv

// ==== source/instr_decode.sv ====
// Instruction decode stage
// Register file with write-through and debug port, control decoding,
// branch and jump resolution, and the ID/EX pipeline register
`timescale 1ns/1ps
`default_nettype none

module instr_decode (
    input  logic                            i_clk,
    input  logic                            i_reset,
    input  logic                            i_enable,
    input  logic [mips_pkg::WORD_W-1:0]     i_instruction,
    input  logic [mips_pkg::WORD_W-1:0]     i_npc,
    input  logic [mips_pkg::WORD_W-1:0]     i_bds_pc,
    input  logic                            i_rf_write,       // From result stage
    input  logic [mips_pkg::REG_ADDR_W-1:0] i_rf_addr,
    input  logic [mips_pkg::WORD_W-1:0]     i_rf_data,
    input  logic [mips_pkg::REG_ADDR_W-1:0] i_dbg_reg_addr,
    output logic [mips_pkg::WORD_W-1:0]     o_dbg_reg_data,
    output logic [mips_pkg::WORD_W-1:0]     o_branch_target,
    output logic [mips_pkg::WORD_W-1:0]     o_jump_target,
    output logic [mips_pkg::WORD_W-1:0]     o_rs_value,
    output logic                            o_pc_src,
    output logic                            o_jump,
    output logic                            o_jump_sel,
    output logic [mips_pkg::WORD_W-1:0]     o_rs_value_ex,
    output logic [mips_pkg::WORD_W-1:0]     o_rt_value_ex,
    output logic [mips_pkg::WORD_W-1:0]     o_imm_ex,
    output mips_pkg::alu_op_t               o_alu_op,
    output logic                            o_alu_src_imm,
    output logic                            o_mem_read,
    output logic                            o_mem_write,
    output logic                            o_reg_write,
    output logic [mips_pkg::REG_ADDR_W-1:0] o_write_reg,
    output logic                            o_link,           // JAL writes link value
    output logic [mips_pkg::WORD_W-1:0]     o_link_value
);
    import mips_pkg::*;

    logic [WORD_W-1:0]     regs [2**REG_ADDR_W];
    logic [REG_ADDR_W-1:0] rs, rt, rd;
    logic [WORD_W-1:0]     rs_value, rt_value, imm_ext;
    alu_op_t               alu_op;
    logic                  alu_src_imm, zero_ext, link;
    logic                  mem_read, mem_write, reg_write;
    logic [REG_ADDR_W-1:0] write_reg;

    assign rs = i_instruction[25:21];
    assign rt = i_instruction[20:16];
    assign rd = i_instruction[15:11];

    // Register 0 reads as zero, a write in flight is seen at once
    function automatic logic [WORD_W-1:0] read_reg(input logic [REG_ADDR_W-1:0] addr);
        if (addr == '0) begin
            return '0;
        end
        if (i_rf_write && i_rf_addr == addr) begin
            return i_rf_data;
        end
        return regs[addr];
    endfunction

    assign rs_value       = read_reg(rs);
    assign rt_value       = read_reg(rt);
    assign o_dbg_reg_data = read_reg(i_dbg_reg_addr);

    always_ff @(posedge i_clk) begin
        if (i_rf_write && i_rf_addr != '0) begin
            regs[i_rf_addr] <= i_rf_data;
        end
    end

    always_comb begin
        alu_op      = ALU_ADD;
        alu_src_imm = 1'b0;
        zero_ext    = 1'b0;
        mem_read    = 1'b0;
        mem_write   = 1'b0;
        reg_write   = 1'b0;
        write_reg   = rt;
        link        = 1'b0;
        o_pc_src    = 1'b0;
        o_jump      = 1'b0;
        o_jump_sel  = 1'b0;
        case (i_instruction[31:26])
            OP_RTYPE: begin
                write_reg = rd;
                reg_write = 1'b1;
                case (i_instruction[5:0])
                    FN_ADDU: alu_op = ALU_ADD;
                    FN_SUBU: alu_op = ALU_SUB;
                    FN_AND:  alu_op = ALU_AND;
                    FN_OR:   alu_op = ALU_OR;
                    FN_XOR:  alu_op = ALU_XOR;
                    FN_SLT:  alu_op = ALU_SLT;
                    FN_JR: begin
                        reg_write  = 1'b0;
                        o_jump     = 1'b1;
                        o_jump_sel = 1'b1;
                    end
                    default: reg_write = 1'b0;            // Also the all-zero NOP
                endcase
            end
            OP_ADDIU: {alu_src_imm, reg_write} = 2'b11;
            OP_ANDI: begin
                alu_op = ALU_AND;
                {alu_src_imm, zero_ext, reg_write} = 3'b111;
            end
            OP_ORI: begin
                alu_op = ALU_OR;
                {alu_src_imm, zero_ext, reg_write} = 3'b111;
            end
            OP_LUI: begin
                alu_op = ALU_LUI;
                {alu_src_imm, reg_write} = 2'b11;
            end
            OP_LW:  {alu_src_imm, mem_read, reg_write} = 3'b111;
            OP_SW:  {alu_src_imm, mem_write} = 2'b11;
            OP_BEQ: o_pc_src = (rs_value == rt_value);
            OP_BNE: o_pc_src = (rs_value != rt_value);
            OP_J:   o_jump = 1'b1;
            OP_JAL: begin
                o_jump    = 1'b1;
                link      = 1'b1;
                reg_write = 1'b1;
                write_reg = REG_ADDR_W'(31);
            end
            default: ;                                    // Unknown, acts as NOP
        endcase
    end

    assign imm_ext = zero_ext ? {16'b0, i_instruction[15:0]}
                              : {{16{i_instruction[15]}}, i_instruction[15:0]};

    assign o_branch_target = i_npc + {imm_ext[WORD_W-3:0], 2'b00};
    assign o_jump_target   = {i_npc[31:28], i_instruction[25:0], 2'b00};
    assign o_rs_value      = rs_value;

    // ID/EX register, controls
    always_ff @(posedge i_clk) begin
        if (i_reset) begin
            o_mem_read  <= 1'b0;
            o_mem_write <= 1'b0;
            o_reg_write <= 1'b0;
        end else if (i_enable) begin
            o_mem_read  <= mem_read;
            o_mem_write <= mem_write;
            o_reg_write <= reg_write;
        end
    end

    // ID/EX register, operands
    always_ff @(posedge i_clk) begin
        if (i_enable) begin
            o_rs_value_ex <= rs_value;
            o_rt_value_ex <= rt_value;
            o_imm_ex      <= imm_ext;
            o_alu_op      <= alu_op;
            o_alu_src_imm <= alu_src_imm;
            o_write_reg   <= write_reg;
            o_link        <= link;
            o_link_value  <= i_bds_pc;
        end
    end

    // Only JR raises jump together with jump_sel, fetch relies on one-hot otherwise
    a_select_onehot: assert property (@(posedge i_clk) disable iff (i_reset)
        !(o_pc_src && (o_jump || o_jump_sel)) && (!o_jump_sel || o_jump));

endmodule

`default_nettype wire

// ==== source/instr_execute.sv ====
// Execute stage
// ALU with immediate operand select, link value override for JAL,
// and the EX/RS pipeline register
`timescale 1ns/1ps
`default_nettype none

module instr_execute (
    input  logic                            i_clk,
    input  logic                            i_reset,
    input  logic                            i_enable,
    input  logic [mips_pkg::WORD_W-1:0]     i_rs_value,
    input  logic [mips_pkg::WORD_W-1:0]     i_rt_value,
    input  logic [mips_pkg::WORD_W-1:0]     i_imm,
    input  mips_pkg::alu_op_t               i_alu_op,
    input  logic                            i_alu_src_imm,
    input  logic                            i_mem_read,
    input  logic                            i_mem_write,
    input  logic                            i_reg_write,
    input  logic [mips_pkg::REG_ADDR_W-1:0] i_write_reg,
    input  logic                            i_link,
    input  logic [mips_pkg::WORD_W-1:0]     i_link_value,
    output logic [mips_pkg::WORD_W-1:0]     o_alu_result,
    output logic [mips_pkg::WORD_W-1:0]     o_store_data,
    output logic                            o_mem_read,
    output logic                            o_mem_write,
    output logic                            o_reg_write,
    output logic [mips_pkg::REG_ADDR_W-1:0] o_write_reg
);
    import mips_pkg::*;

    logic [WORD_W-1:0] operand_b;
    logic [WORD_W-1:0] alu_out;

    assign operand_b = i_alu_src_imm ? i_imm : i_rt_value;

    always_comb begin
        case (i_alu_op)
            ALU_ADD: alu_out = i_rs_value + operand_b;
            ALU_SUB: alu_out = i_rs_value - operand_b;
            ALU_AND: alu_out = i_rs_value & operand_b;
            ALU_OR:  alu_out = i_rs_value | operand_b;
            ALU_XOR: alu_out = i_rs_value ^ operand_b;
            ALU_SLT: alu_out = WORD_W'($signed(i_rs_value) < $signed(operand_b));
            ALU_LUI: alu_out = {operand_b[15:0], 16'b0};
            default: alu_out = '0;
        endcase
    end

    always_ff @(posedge i_clk) begin
        if (i_reset) begin
            o_mem_read  <= 1'b0;
            o_mem_write <= 1'b0;
            o_reg_write <= 1'b0;
        end else if (i_enable) begin
            o_mem_read  <= i_mem_read;
            o_mem_write <= i_mem_write;
            o_reg_write <= i_reg_write;
        end
    end

    always_ff @(posedge i_clk) begin
        if (i_enable) begin
            o_alu_result <= i_link ? i_link_value : alu_out;  // JAL return address
            o_store_data <= i_rt_value;
            o_write_reg  <= i_write_reg;
        end
    end

endmodule

`default_nettype wire

// ==== source/instr_fetch.sv ====
// Instruction fetch stage
// Holds the PC, picks the next PC from decode's selects and fetches from
// an instruction memory that is loaded word by word while the core is halted
`timescale 1ns/1ps
`default_nettype none

module instr_fetch #(
    parameter int IMEM_ADDR_W = 10
) (
    input  logic                        i_clk,
    input  logic                        i_reset,
    input  logic                        i_enable,         // Run the pipeline
    input  logic                        i_write,          // Load strobe
    input  logic [mips_pkg::WORD_W-1:0] i_instruction,    // Word to load
    input  logic [mips_pkg::WORD_W-1:0] i_branch_target,
    input  logic [mips_pkg::WORD_W-1:0] i_jump_target,
    input  logic [mips_pkg::WORD_W-1:0] i_rs_value,       // JR target
    input  logic                        i_pc_src,         // Take branch
    input  logic                        i_jump,
    input  logic                        i_jump_sel,       // Jump to register
    output logic [mips_pkg::WORD_W-1:0] o_pc,
    output logic [mips_pkg::WORD_W-1:0] o_npc,            // PC+4 of decoded word
    output logic [mips_pkg::WORD_W-1:0] o_bds_pc,         // PC+8 of decoded word
    output logic [mips_pkg::WORD_W-1:0] o_instruction
);
    import mips_pkg::*;

    logic [WORD_W-1:0]      imem [2**IMEM_ADDR_W];
    logic [IMEM_ADDR_W-1:0] load_ptr;
    logic [WORD_W-1:0]      pc_plus4;
    logic [WORD_W-1:0]      next_pc;

    assign pc_plus4 = o_pc + WORD_W'(4);

    // JR wins over J/JAL, which wins over a taken branch
    always_comb begin
        next_pc = pc_plus4;
        if (i_jump_sel) begin
            next_pc = i_rs_value;
        end else if (i_jump) begin
            next_pc = i_jump_target;
        end else if (i_pc_src) begin
            next_pc = i_branch_target;
        end
    end

    always_ff @(posedge i_clk) begin
        if (i_reset) begin
            o_pc          <= '0;
            o_instruction <= '0;                          // NOP
        end else if (i_enable) begin
            o_pc          <= next_pc;
            o_instruction <= imem[o_pc[IMEM_ADDR_W+1:2]];
        end
    end

    // Link and branch base addresses travel with the fetched word
    always_ff @(posedge i_clk) begin
        if (i_enable) begin
            o_npc    <= pc_plus4;
            o_bds_pc <= o_pc + WORD_W'(8);
        end
    end

    // Program loading, only while halted
    always_ff @(posedge i_clk) begin
        if (i_reset) begin
            load_ptr <= '0;
        end else if (i_write && !i_enable) begin
            load_ptr <= load_ptr + 1'b1;
        end
    end

    always_ff @(posedge i_clk) begin
        if (i_write && !i_enable) begin
            imem[load_ptr] <= i_instruction;
        end
    end

    // Loading and running never overlap
    a_no_load_while_running: assert property (@(posedge i_clk) disable iff (i_reset)
        $rose(i_write) |-> !i_enable);

    // Branch, jump and JR targets must all be word addresses
    a_pc_aligned: assert property (@(posedge i_clk) disable iff (i_reset)
        o_pc[1:0] == 2'b00);

endmodule

`default_nettype wire

// ==== source/mips_core.sv ====
// MIPS core top level
// Four-stage in-order pipeline: fetch, decode, execute, result
`timescale 1ns/1ps
`default_nettype none

module mips_core #(
    parameter int IMEM_ADDR_W = 10,
    parameter int DMEM_ADDR_W = 8
) (
    input  logic                            i_clk,
    input  logic                            i_reset,
    input  logic                            i_enable,
    input  logic                            i_write,
    input  logic [mips_pkg::WORD_W-1:0]     i_instruction,
    input  logic [mips_pkg::REG_ADDR_W-1:0] i_dbg_reg_addr,
    output logic [mips_pkg::WORD_W-1:0]     o_dbg_reg_data,
    output logic [mips_pkg::WORD_W-1:0]     o_pc
);
    import mips_pkg::*;

    // Fetch and decode
    logic [WORD_W-1:0]     if_instruction, if_npc, if_bds_pc;
    logic [WORD_W-1:0]     id_branch_target, id_jump_target, id_rs_value;
    logic                  id_pc_src, id_jump, id_jump_sel;

    // ID/EX
    logic [WORD_W-1:0]     ex_rs_value, ex_rt_value, ex_imm, ex_link_value;
    alu_op_t               ex_alu_op;
    logic                  ex_alu_src_imm, ex_mem_read, ex_mem_write, ex_reg_write, ex_link;
    logic [REG_ADDR_W-1:0] ex_write_reg;

    // EX/RS and write-back
    logic [WORD_W-1:0]     rs_alu_result, rs_store_data, wb_data;
    logic                  rs_mem_read, rs_mem_write, rs_reg_write, wb_write;
    logic [REG_ADDR_W-1:0] rs_write_reg, wb_addr;

    instr_fetch #(.IMEM_ADDR_W(IMEM_ADDR_W)) i_instr_fetch (
        .i_clk, .i_reset, .i_enable, .i_write, .i_instruction,
        .i_branch_target(id_branch_target), .i_jump_target(id_jump_target),
        .i_rs_value(id_rs_value), .i_pc_src(id_pc_src), .i_jump(id_jump),
        .i_jump_sel(id_jump_sel), .o_pc, .o_npc(if_npc), .o_bds_pc(if_bds_pc),
        .o_instruction(if_instruction)
    );

    instr_decode i_instr_decode (
        .i_clk, .i_reset, .i_enable, .i_instruction(if_instruction),
        .i_npc(if_npc), .i_bds_pc(if_bds_pc),
        .i_rf_write(wb_write), .i_rf_addr(wb_addr), .i_rf_data(wb_data),
        .i_dbg_reg_addr, .o_dbg_reg_data,
        .o_branch_target(id_branch_target), .o_jump_target(id_jump_target),
        .o_rs_value(id_rs_value), .o_pc_src(id_pc_src), .o_jump(id_jump),
        .o_jump_sel(id_jump_sel), .o_rs_value_ex(ex_rs_value),
        .o_rt_value_ex(ex_rt_value), .o_imm_ex(ex_imm), .o_alu_op(ex_alu_op),
        .o_alu_src_imm(ex_alu_src_imm), .o_mem_read(ex_mem_read),
        .o_mem_write(ex_mem_write), .o_reg_write(ex_reg_write),
        .o_write_reg(ex_write_reg), .o_link(ex_link), .o_link_value(ex_link_value)
    );

    instr_execute i_instr_execute (
        .i_clk, .i_reset, .i_enable, .i_rs_value(ex_rs_value),
        .i_rt_value(ex_rt_value), .i_imm(ex_imm), .i_alu_op(ex_alu_op),
        .i_alu_src_imm(ex_alu_src_imm), .i_mem_read(ex_mem_read),
        .i_mem_write(ex_mem_write), .i_reg_write(ex_reg_write),
        .i_write_reg(ex_write_reg), .i_link(ex_link), .i_link_value(ex_link_value),
        .o_alu_result(rs_alu_result), .o_store_data(rs_store_data),
        .o_mem_read(rs_mem_read), .o_mem_write(rs_mem_write),
        .o_reg_write(rs_reg_write), .o_write_reg(rs_write_reg)
    );

    result_stage #(.DMEM_ADDR_W(DMEM_ADDR_W)) i_result_stage (
        .i_clk, .i_reset, .i_enable, .i_alu_result(rs_alu_result),
        .i_store_data(rs_store_data), .i_mem_read(rs_mem_read),
        .i_mem_write(rs_mem_write), .i_reg_write(rs_reg_write),
        .i_write_reg(rs_write_reg), .o_rf_write(wb_write), .o_rf_addr(wb_addr),
        .o_rf_data(wb_data)
    );

endmodule

`default_nettype wire

// ==== source/mips_pkg.sv ====
// MIPS core shared definitions
// Word widths, opcode and function encodings, ALU operations
`default_nettype none

package mips_pkg;

    localparam int WORD_W     = 32;  // Data and instruction width
    localparam int REG_ADDR_W = 5;   // 32 architectural registers

    // Primary opcodes, instruction bits 31:26
    typedef enum logic [5:0] {
        OP_RTYPE = 6'h00,
        OP_J     = 6'h02,
        OP_JAL   = 6'h03,
        OP_BEQ   = 6'h04,
        OP_BNE   = 6'h05,
        OP_ADDIU = 6'h09,
        OP_ANDI  = 6'h0C,
        OP_ORI   = 6'h0D,
        OP_LUI   = 6'h0F,
        OP_LW    = 6'h23,
        OP_SW    = 6'h2B
    } opcode_t;

    // R-type function codes, instruction bits 5:0
    typedef enum logic [5:0] {
        FN_JR   = 6'h08,
        FN_ADDU = 6'h21,
        FN_SUBU = 6'h23,
        FN_AND  = 6'h24,
        FN_OR   = 6'h25,
        FN_XOR  = 6'h26,
        FN_SLT  = 6'h2A
    } funct_t;

    typedef enum logic [3:0] {
        ALU_ADD = 4'd0,
        ALU_SUB = 4'd1,
        ALU_AND = 4'd2,
        ALU_OR  = 4'd3,
        ALU_XOR = 4'd4,
        ALU_SLT = 4'd5,
        ALU_LUI = 4'd6
    } alu_op_t;

endpackage

`default_nettype wire

// ==== source/result_stage.sv ====
// Result stage
// Word-wide data memory for LW and SW, and the register file write request
`timescale 1ns/1ps
`default_nettype none

module result_stage #(
    parameter int DMEM_ADDR_W = 8
) (
    input  logic                            i_clk,
    input  logic                            i_reset,
    input  logic                            i_enable,
    input  logic [mips_pkg::WORD_W-1:0]     i_alu_result,     // Address or result
    input  logic [mips_pkg::WORD_W-1:0]     i_store_data,
    input  logic                            i_mem_read,
    input  logic                            i_mem_write,
    input  logic                            i_reg_write,
    input  logic [mips_pkg::REG_ADDR_W-1:0] i_write_reg,
    output logic                            o_rf_write,
    output logic [mips_pkg::REG_ADDR_W-1:0] o_rf_addr,
    output logic [mips_pkg::WORD_W-1:0]     o_rf_data
);
    import mips_pkg::*;

    logic [WORD_W-1:0]      dmem [2**DMEM_ADDR_W];
    logic [DMEM_ADDR_W-1:0] dmem_addr;

    assign dmem_addr = i_alu_result[DMEM_ADDR_W+1:2];     // Word index

    always_ff @(posedge i_clk) begin
        if (i_enable && i_mem_write) begin
            dmem[dmem_addr] <= i_store_data;
        end
    end

    assign o_rf_write = i_reg_write;
    assign o_rf_addr  = i_write_reg;
    assign o_rf_data  = i_mem_read ? dmem[dmem_addr] : i_alu_result;

    // Base plus offset from decode must land on a word boundary
    a_dmem_aligned: assert property (@(posedge i_clk) disable iff (i_reset)
        (i_mem_read || i_mem_write) |-> i_alu_result[1:0] == 2'b00);

endmodule

`default_nettype wire
